//--- Bender.yml
package:
  name: dispatch_memory

sources:
  - files:
      - design/dispatch_pkg.sv
      - design/dispatch_ram.sv
      - design/dispatch_sequencer.sv
      - design/dispatch_wb_port.sv
      - design/dispatch_top.sv
  - target: test
    files:
      - tests/dispatch_tb_checks.sv
      - tests/dispatch_tb.sv

//--- all.f
design/dispatch_pkg.sv
design/dispatch_ram.sv
design/dispatch_sequencer.sv
design/dispatch_wb_port.sv
design/dispatch_top.sv
tests/dispatch_tb_checks.sv
tests/dispatch_tb.sv

//--- design/dispatch_pkg.sv
// fixed 17-bit entry format with a 14-bit micro-PC; all enums are 2 bits wide
`default_nettype none

package dispatch_pkg;

   localparam int upc_width = 14;   // micro-PC width
   localparam int entry_width = 17; // one dispatch table entry

   // entry layout
   localparam int target_lsb = 0;   // target micro-PC in 13..0
   localparam int r_bit = 14;       // return flag
   localparam int p_bit = 15;       // push flag, gives a call
   localparam int n_bit = 16;       // inhibit flag, gives a skip

   // branch action handed to the micro-sequencer, decoded n > r > p > jump
   typedef enum logic [1:0]
   {
      act_jump   = 2'd0,
      act_call   = 2'd1,
      act_return = 2'd2,
      act_skip   = 2'd3
   } dispatch_action_e;

   // dispatch sequencer FSM
   typedef enum logic [1:0]
   {
      st_idle   = 2'd0,  // waiting for a request
      st_read   = 2'd1,  // port a read in progress
      st_result = 2'd2   // decode, then hold until taken
   } seq_state_e;

   // host side Wishbone FSM
   typedef enum logic [1:0]
   {
      wb_idle = 2'd0,
      wb_ack  = 2'd1     // single ack cycle
   } wb_state_e;

endpackage

`default_nettype wire

//--- design/dispatch_ram.sv
// behavioral model only; both ports on clk_a, port a read-only, mixed-port reads give old data
`timescale 1ns/1ps
`default_nettype none

module dispatch_ram
#(
   parameter int addr_width = 11
)
(
   input  wire logic                               clk_a,
   input  wire logic                               reset,

   // dispatch side, read only
   input  wire logic [addr_width-1:0]              address_a,
   input  wire logic                               rden_a,
   output logic      [dispatch_pkg::entry_width-1:0] q_a,

   // host side
   input  wire logic [addr_width-1:0]              address_b,
   input  wire logic [dispatch_pkg::entry_width-1:0] data_b,
   input  wire logic                               wren_b,
   input  wire logic                               rden_b,
   output logic      [dispatch_pkg::entry_width-1:0] q_b
);

   localparam int depth = 2 ** addr_width;

   logic [dispatch_pkg::entry_width-1:0] mem [0:depth-1];
   logic [dispatch_pkg::entry_width-1:0] out_a;
   logic [dispatch_pkg::entry_width-1:0] out_b;

   // table writes come only from the host port
   always_ff @(posedge clk_a)
   begin
      if (wren_b)
      begin
         mem[address_b] <= data_b;
      end
   end

   // port a read register, holds while rden_a is low
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_a <= '0;
      end
      else if (rden_a)
      begin
         out_a <= mem[address_a];  // old data on a same-edge write
      end
   end

   // port b read register
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_b <= '0;
      end
      else if (rden_b)
      begin
         out_b <= mem[address_b];
      end
   end

   assign q_a = out_a;
   assign q_b = out_b;

   // the host port issues either a read or a write per cycle, never both
   assert property (@(posedge clk_a) disable iff (reset)
      !(wren_b && rden_b))
   else $error("dispatch_ram: wren_b and rden_b high together on port b");

endmodule

`default_nettype wire

//--- design/dispatch_sequencer.sv
// one request in flight; requester holds request fields while req_valid is high; width 0 acts as 1
`timescale 1ns/1ps
`default_nettype none

module dispatch_sequencer
#(
   parameter int addr_width = 11
)
(
   input  wire logic                                 clk_a,
   input  wire logic                                 reset,

   // dispatch request
   input  wire logic                                 req_valid,
   output logic                                      req_ready,
   input  wire logic [31:0]                          req_source,
   input  wire logic [4:0]                           req_rot,
   input  wire logic [2:0]                           req_width,
   input  wire logic [addr_width-1:0]                req_base,
   input  wire logic [dispatch_pkg::upc_width-1:0]   req_upc,

   // dispatch result
   output logic                                      res_valid,
   input  wire logic                                 res_ready,
   output dispatch_pkg::dispatch_action_e            res_action,
   output logic      [dispatch_pkg::upc_width-1:0]   res_target,
   output logic      [dispatch_pkg::upc_width-1:0]   res_link,

   // RAM port a
   output logic      [addr_width-1:0]                address_a,
   output logic                                      rden_a,
   input  wire logic [dispatch_pkg::entry_width-1:0] q_a
);

   dispatch_pkg::seq_state_e state;

   logic                                accept;
   logic [63:0]                         src_pair;
   logic [63:0]                         src_shifted;
   logic [addr_width-1:0]               field_bits;
   logic [2:0]                          eff_width;
   logic [addr_width-1:0]               field_mask;
   logic [addr_width-1:0]               next_addr;
   logic [addr_width-1:0]               addr_q;
   logic [dispatch_pkg::upc_width-1:0]  link_q;
   dispatch_pkg::dispatch_action_e      decoded_action;

   assign req_ready = (state == dispatch_pkg::st_idle);
   assign accept = req_valid && req_ready;

   // rotate right by doubling the word, then splice the field into the base
   always_comb
   begin
      src_pair = {req_source, req_source};
      src_shifted = src_pair >> req_rot;
      field_bits = src_shifted[addr_width-1:0];
      eff_width = (req_width == 3'd0) ? 3'd1 : req_width;       // 0 is read as 1
      field_mask = ~({addr_width{1'b1}} << eff_width);
      next_addr = (req_base & ~field_mask) | (field_bits & field_mask);
   end

   // n beats r beats p
   always_comb
   begin
      if (q_a[dispatch_pkg::n_bit])
      begin
         decoded_action = dispatch_pkg::act_skip;
      end
      else if (q_a[dispatch_pkg::r_bit])
      begin
         decoded_action = dispatch_pkg::act_return;
      end
      else if (q_a[dispatch_pkg::p_bit])
      begin
         decoded_action = dispatch_pkg::act_call;
      end
      else
      begin
         decoded_action = dispatch_pkg::act_jump;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= dispatch_pkg::st_idle;
         res_valid <= 1'b0;
      end
      else
      begin
         case (state)
            dispatch_pkg::st_idle:
               if (accept)
               begin
                  state <= dispatch_pkg::st_read;
               end
            dispatch_pkg::st_read:
               state <= dispatch_pkg::st_result;   // q_a lands on this edge
            dispatch_pkg::st_result:
               if (!res_valid)
               begin
                  res_valid <= 1'b1;               // capture edge
               end
               else if (res_ready)
               begin
                  res_valid <= 1'b0;
                  state <= dispatch_pkg::st_idle;
               end
            default:
               state <= dispatch_pkg::st_idle;
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk_a)
   begin
      if (accept)
      begin
         addr_q <= next_addr;
         link_q <= req_upc + 1'b1;                 // wraps at upc_width
      end
      if ((state == dispatch_pkg::st_result) && !res_valid)
      begin
         res_action <= decoded_action;
         res_target <= q_a[dispatch_pkg::target_lsb +: dispatch_pkg::upc_width];
      end
   end

   assign address_a = addr_q;
   assign rden_a = (state == dispatch_pkg::st_read);  // one cycle per request
   assign res_link = link_q;

   // result is frozen while the consumer stalls
   assert property (@(posedge clk_a) disable iff (reset)
      (res_valid && !res_ready) |=>
         (res_valid && $stable(res_action) && $stable(res_target) && $stable(res_link)))
   else $error("dispatch_sequencer: result changed while res_ready was low");

endmodule

`default_nettype wire

//--- design/dispatch_top.sv
// single clock clk_a for both RAM ports; adds no registers, latencies are those of the sub-blocks
`timescale 1ns/1ps
`default_nettype none

module dispatch_top
#(
   parameter int addr_width = 11  // 9 and 10 also supported
)
(
   input  wire logic                                 clk_a,
   input  wire logic                                 reset,

   // dispatch request
   input  wire logic                                 req_valid,
   output logic                                      req_ready,
   input  wire logic [31:0]                          req_source,
   input  wire logic [4:0]                           req_rot,
   input  wire logic [2:0]                           req_width,
   input  wire logic [addr_width-1:0]                req_base,
   input  wire logic [dispatch_pkg::upc_width-1:0]   req_upc,

   // dispatch result
   output logic                                      res_valid,
   input  wire logic                                 res_ready,
   output dispatch_pkg::dispatch_action_e            res_action,
   output logic      [dispatch_pkg::upc_width-1:0]   res_target,
   output logic      [dispatch_pkg::upc_width-1:0]   res_link,

   // host Wishbone
   input  wire logic                                 wb_cyc,
   input  wire logic                                 wb_stb,
   input  wire logic                                 wb_we,
   input  wire logic [addr_width-1:0]                wb_adr,
   input  wire logic [31:0]                          wb_dat_w,
   output logic      [31:0]                          wb_dat_r,
   output logic                                      wb_ack
);

   logic [addr_width-1:0]                address_a;
   logic                                 rden_a;
   logic [dispatch_pkg::entry_width-1:0] q_a;
   logic [addr_width-1:0]                address_b;
   logic [dispatch_pkg::entry_width-1:0] data_b;
   logic                                 wren_b;
   logic                                 rden_b;
   logic [dispatch_pkg::entry_width-1:0] q_b;

   dispatch_sequencer #(.addr_width(addr_width)) dispatch_sequencer_i
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_source (req_source),
      .req_rot    (req_rot),
      .req_width  (req_width),
      .req_base   (req_base),
      .req_upc    (req_upc),
      .res_valid  (res_valid),
      .res_ready  (res_ready),
      .res_action (res_action),
      .res_target (res_target),
      .res_link   (res_link),
      .address_a  (address_a),
      .rden_a     (rden_a),
      .q_a        (q_a)
   );

   dispatch_wb_port #(.addr_width(addr_width)) dispatch_wb_port_i
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .address_b (address_b),
      .data_b    (data_b),
      .wren_b    (wren_b),
      .rden_b    (rden_b),
      .q_b       (q_b)
   );

   dispatch_ram #(.addr_width(addr_width)) dispatch_ram_i
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (address_a),
      .rden_a    (rden_a),
      .q_a       (q_a),
      .address_b (address_b),
      .data_b    (data_b),
      .wren_b    (wren_b),
      .rden_b    (rden_b),
      .q_b       (q_b)
   );

endmodule

`default_nettype wire

//--- design/dispatch_wb_port.sv
// Wishbone classic slave, word addressed, low 17 data bits used; host must drop wb_stb after wb_ack
`timescale 1ns/1ps
`default_nettype none

module dispatch_wb_port
#(
   parameter int addr_width = 11
)
(
   input  wire logic                                 clk_a,
   input  wire logic                                 reset,

   // Wishbone slave
   input  wire logic                                 wb_cyc,
   input  wire logic                                 wb_stb,
   input  wire logic                                 wb_we,
   input  wire logic [addr_width-1:0]                wb_adr,
   input  wire logic [31:0]                          wb_dat_w,
   output logic      [31:0]                          wb_dat_r,
   output logic                                      wb_ack,

   // RAM port b
   output logic      [addr_width-1:0]                address_b,
   output logic      [dispatch_pkg::entry_width-1:0] data_b,
   output logic                                      wren_b,
   output logic                                      rden_b,
   input  wire logic [dispatch_pkg::entry_width-1:0] q_b
);

   dispatch_pkg::wb_state_e state;

   logic start;

   // a new active cycle is only taken from idle
   assign start = (state == dispatch_pkg::wb_idle) && wb_cyc && wb_stb;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= dispatch_pkg::wb_idle;
      end
      else
      begin
         case (state)
            dispatch_pkg::wb_idle:
               if (start)
               begin
                  state <= dispatch_pkg::wb_ack;
               end
            dispatch_pkg::wb_ack:
               state <= dispatch_pkg::wb_idle;    // host drops stb on this edge
            default:
               state <= dispatch_pkg::wb_idle;
         endcase
      end
   end

   // the RAM access happens on the edge that first sees the cycle
   assign address_b = wb_adr;
   assign data_b = wb_dat_w[dispatch_pkg::entry_width-1:0];
   assign wren_b = start && wb_we;
   assign rden_b = start && !wb_we;

   assign wb_ack = (state == dispatch_pkg::wb_ack);
   assign wb_dat_r = {{(32 - dispatch_pkg::entry_width){1'b0}}, q_b};  // read data valid with ack

   // ack never shows up outside an active bus cycle
   assert property (@(posedge clk_a) disable iff (reset)
      wb_ack |-> (wb_cyc && wb_stb))
   else $error("dispatch_wb_port: wb_ack high without an active cycle");

endmodule

`default_nettype wire

//--- tests/dispatch_tb.sv
// table entries 0..127 are loaded first; later dispatches only reach loaded addresses
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb;

   localparam int addr_width = 11;

   logic clk_a;
   logic reset;
   logic req_valid;
   logic req_ready;
   logic [31:0] req_source;
   logic [4:0] req_rot;
   logic [2:0] req_width;
   logic [addr_width-1:0] req_base;
   logic [13:0] req_upc;
   logic res_valid;
   logic res_ready;
   dispatch_pkg::dispatch_action_e res_action;
   logic [13:0] res_target;
   logic [13:0] res_link;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [addr_width-1:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic wb_ack;

   int cycles = 0;
   int wait_errors = 0;
   int last_errors = 0;
   int tests_ok = 0;
   int tests_bad = 0;
   logic [2:0] flag_set [0:4] = '{3'b010, 3'b001, 3'b011, 3'b100, 3'b111};  // n p r in 16..14

   initial
   begin
      clk_a = 1'b0;
      forever #20 clk_a = ~clk_a;
   end

   always @(posedge clk_a)
   begin
      cycles++;
      if (cycles >= 4000)
      begin
         $display("timeout after %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   dispatch_top #(.addr_width(addr_width)) dispatch_top_i
   (
      .clk_a(clk_a), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req_source(req_source),
      .req_rot(req_rot), .req_width(req_width), .req_base(req_base), .req_upc(req_upc),
      .res_valid(res_valid), .res_ready(res_ready), .res_action(res_action),
      .res_target(res_target), .res_link(res_link),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   dispatch_tb_checks #(.addr_width(addr_width)) checks_i
   (
      .clk_a(clk_a), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req_source(req_source),
      .req_rot(req_rot), .req_width(req_width), .req_base(req_base), .req_upc(req_upc),
      .res_valid(res_valid), .res_ready(res_ready), .res_action(res_action),
      .res_target(res_target), .res_link(res_link),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   task automatic wait_ack();
      int n;
      n = 0;
      @(negedge clk_a);
      while (!wb_ack && n < 10)
      begin
         @(negedge clk_a);
         n++;
      end
      if (!wb_ack)
      begin
         wait_errors++;
         $display("no wb_ack for address %h", wb_adr);
      end
   endtask

   task automatic wait_result();
      int n;
      n = 0;
      @(negedge clk_a);
      while (!res_valid && n < 10)
      begin
         @(negedge clk_a);
         n++;
      end
      if (!res_valid)
      begin
         wait_errors++;
         $display("no res_valid for base %h", req_base);
      end
   endtask

   task automatic wb_access(input logic we, input logic [addr_width-1:0] adr,
      input logic [31:0] data);
      @(posedge clk_a);
      #2;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = data;
      wait_ack();
      @(posedge clk_a);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic drive_request(input logic [31:0] src, input logic [4:0] rot,
      input logic [2:0] width, input logic [addr_width-1:0] base, input logic [13:0] upc);
      @(posedge clk_a);
      #2;
      req_valid = 1'b1;
      req_source = src;
      req_rot = rot;
      req_width = width;
      req_base = base;
      req_upc = upc;
      @(negedge clk_a);
      if (!req_ready)
      begin
         wait_errors++;
         $display("req_ready low while the sequencer should be idle");
      end
      @(posedge clk_a);                      // accept edge
      #2;
      req_valid = 1'b0;
   endtask

   task automatic dispatch(input logic [31:0] src, input logic [4:0] rot,
      input logic [2:0] width, input logic [addr_width-1:0] base, input logic [13:0] upc,
      input int stall);
      res_ready = (stall == 0);
      drive_request(src, rot, width, base, upc);
      wait_result();
      if (stall > 0)
      begin
         repeat (stall) @(posedge clk_a);
         #2;
         res_ready = 1'b1;
      end
      @(posedge clk_a);                      // transfer edge
      #2;
   endtask

   task automatic end_test(input string name);
      int now;
      now = checks_i.errors + wait_errors;
      if (now == last_errors)
      begin
         tests_ok++;
         $display("%s: ok", name);
      end
      else
      begin
         tests_bad++;
         $display("%s: %0d errors", name, now - last_errors);
      end
      last_errors = now;
   endtask

   initial
   begin
      logic [16:0] entry;
      logic [addr_width-1:0] a;
      void'($urandom(64648));
      reset = 1'b1;
      req_valid = 1'b0;
      req_source = '0;
      req_rot = '0;
      req_width = '0;
      req_base = '0;
      req_upc = '0;
      res_ready = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      repeat (8) @(posedge clk_a);
      #2;
      reset = 1'b0;

      for (int i = 0; i < 128; i++)
      begin
         wb_access(1'b1, i, $urandom);        // upper bits random, must read back 0
      end
      for (int i = 0; i < 128; i++)
      begin
         wb_access(1'b0, i, 32'd0);
      end
      end_test("reset and table load");

      for (int i = 0; i < 8; i++)
      begin
         a = 16 + i;
         wb_access(1'b1, a, {18'd0, 14'($urandom)});
         dispatch({31'd0, a[0]}, 5'd0, 3'd1, a, (i == 0) ? 14'h3fff : 14'($urandom), 0);
      end
      end_test("jump dispatch");

      for (int i = 0; i < 5; i++)
      begin
         a = 100 + i;
         entry = {flag_set[i], 14'($urandom)};
         wb_access(1'b1, a, {15'd0, entry});
         dispatch({31'd0, a[0]}, 5'd0, 3'd1, a, 14'($urandom), 0);
      end
      end_test("action priority");

      for (int i = 0; i < 100; i++)
      begin
         dispatch($urandom, 5'($urandom), 3'($urandom), 11'($urandom % 128),
            14'($urandom), 0);
      end
      end_test("field extraction");

      for (int i = 0; i < 10; i++)
      begin
         dispatch($urandom, 5'($urandom), 3'($urandom), 11'($urandom % 128),
            14'($urandom), 1 + ($urandom % 8));
      end
      end_test("back-pressure");

      a = 11'd40;
      wb_access(1'b1, a, 32'h0000_1234);
      res_ready = 1'b1;
      drive_request({31'd0, a[0]}, 5'd0, 3'd1, a, 14'h0100);
      wb_cyc = 1'b1;                         // write lands on the port a read edge
      wb_stb = 1'b1;
      wb_we = 1'b1;
      wb_adr = a;
      wb_dat_w = 32'h0001_4321;
      wait_ack();
      @(posedge clk_a);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wait_result();
      @(posedge clk_a);
      #2;
      dispatch({31'd0, a[0]}, 5'd0, 3'd1, a, 14'h0200, 0);
      end_test("mixed access");

      $display("tests passed %0d failed %0d", tests_ok, tests_bad);
      if (tests_bad == 0 && (checks_i.errors + wait_errors) == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/dispatch_tb_checks.sv
// shadow model of the dispatch table; only addresses written over Wishbone give defined results
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb_checks
#(
   parameter int addr_width = 11
)
(
   input  wire logic                  clk_a,
   input  wire logic                  reset,
   input  wire logic                  req_valid,
   input  wire logic                  req_ready,
   input  wire logic [31:0]           req_source,
   input  wire logic [4:0]            req_rot,
   input  wire logic [2:0]            req_width,
   input  wire logic [addr_width-1:0] req_base,
   input  wire logic [13:0]           req_upc,
   input  wire logic                  res_valid,
   input  wire logic                  res_ready,
   input  wire logic [1:0]            res_action,
   input  wire logic [13:0]           res_target,
   input  wire logic [13:0]           res_link,
   input  wire logic                  wb_cyc,
   input  wire logic                  wb_stb,
   input  wire logic                  wb_we,
   input  wire logic [addr_width-1:0] wb_adr,
   input  wire logic [31:0]           wb_dat_w,
   input  wire logic [31:0]           wb_dat_r,
   input  wire logic                  wb_ack
);

   int errors = 0;

   logic [16:0]           shadow [0:(2**addr_width)-1];
   logic                  wb_pend;     // ack cycle expected
   logic                  read_stage;  // port a read edge comes next
   logic [addr_width-1:0] exp_addr;
   logic [13:0]           exp_link;
   logic [16:0]           exp_entry;
   logic [31:0]           exp_rd;

   // bit i of the field is source bit (i + rot) mod 32
   function automatic logic [addr_width-1:0] rule_addr(input logic [31:0] src,
      input logic [4:0] rot, input logic [2:0] width, input logic [addr_width-1:0] base);
      int w;
      logic [addr_width-1:0] a;
      a = base;
      w = (width == 3'd0) ? 1 : int'(width);
      for (int i = 0; i < w; i++)
      begin
         a[i] = src[(i + int'(rot)) % 32];
      end
      return a;
   endfunction

   // n is bit 16, r is bit 14, p is bit 15
   function automatic logic [1:0] flags_to_action(input logic [16:0] entry);
      casez ({entry[16], entry[14], entry[15]})   // n r p
         3'b1??:  return dispatch_pkg::act_skip;
         3'b01?:  return dispatch_pkg::act_return;
         3'b001:  return dispatch_pkg::act_call;
         default: return dispatch_pkg::act_jump;
      endcase
   endfunction

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         wb_pend <= 1'b0;
         read_stage <= 1'b0;
      end
      else
      begin
         wb_pend <= wb_cyc && wb_stb && !wb_pend;
         if (wb_cyc && wb_stb && !wb_pend)
         begin
            if (wb_we)
            begin
               shadow[wb_adr] <= wb_dat_w[16:0];
            end
            else
            begin
               exp_rd <= {15'd0, shadow[wb_adr]};
            end
         end
         read_stage <= req_valid && req_ready;
         if (req_valid && req_ready)
         begin
            exp_addr <= rule_addr(req_source, req_rot, req_width, req_base);
            exp_link <= req_upc + 14'd1;    // wraps at 14 bits
         end
         if (read_stage)
         begin
            exp_entry <= shadow[exp_addr];  // old data if written on this edge
         end
      end
   end

   assert property (@(posedge clk_a) $fell(reset) |-> (req_ready && !res_valid && !wb_ack))
   else
   begin
      errors++;
      $display("outputs not idle after reset");
   end

   assert property (@(posedge clk_a) disable iff (reset) wb_pend |-> wb_ack)
   else
   begin
      errors++;
      $display("wb_ack missing one cycle after the bus cycle began");
   end

   assert property (@(posedge clk_a) disable iff (reset) wb_ack |=> !wb_ack)
   else
   begin
      errors++;
      $display("wb_ack stayed high for more than one cycle");
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (wb_ack && !wb_we) |-> (wb_dat_r == exp_rd))
   else
   begin
      errors++;
      $display("** Error wb_dat_r expected %h got %h", $sampled(exp_rd), $sampled(wb_dat_r));
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (req_valid && req_ready) |=> !res_valid ##1 !res_valid ##1 res_valid)
   else
   begin
      errors++;
      $display("res_valid did not rise 2 edges after the accept");
   end

   assert property (@(posedge clk_a) disable iff (reset) res_valid |-> !req_ready)
   else
   begin
      errors++;
      $display("req_ready high while a result was pending");
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (res_valid && !res_ready) |=> (res_valid && $stable(res_action)
         && $stable(res_target) && $stable(res_link)))
   else
   begin
      errors++;
      $display("result changed while stalled");
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (res_valid && res_ready) |-> (res_target == exp_entry[13:0]))
   else
   begin
      errors++;
      $display("** Error res_target expected %h got %h",
         $sampled(exp_entry[13:0]), $sampled(res_target));
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (res_valid && res_ready) |-> (res_action == flags_to_action(exp_entry)))
   else
   begin
      errors++;
      $display("** Error res_action expected %h got %h",
         flags_to_action($sampled(exp_entry)), $sampled(res_action));
   end

   assert property (@(posedge clk_a) disable iff (reset)
      (res_valid && res_ready) |-> (res_link == exp_link))
   else
   begin
      errors++;
      $display("** Error res_link expected %h got %h", $sampled(exp_link), $sampled(res_link));
   end

endmodule

`default_nettype wire
